// File: common/ahb_cache_pkg.sv
package ahb_cache_pkg;

    // byte address and bus word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // four words per line, word 0 in the low bits
    localparam int LINE_WORDS = 4;

    typedef logic [LINE_WORDS*32-1:0] line_t;

    // word index inside a line, address bits 3:2
    typedef logic [1:0] word_sel_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef logic [2:0] hburst_t;

    localparam hburst_t HBURST_SINGLE = 3'b000;
    localparam hburst_t HBURST_INCR   = 3'b001;
    localparam hburst_t HBURST_WRAP4  = 3'b010;

    // address phase of one AHB-lite master
    typedef struct packed {
        addr_t   haddr;
        htrans_t htrans;
        logic    hwrite;
        hburst_t hburst;
    } ahb_req_t;

    // slave side, data and wait state
    typedef struct packed {
        data_t hrdata;
        logic  hready;
    } ahb_rsp_t;

endpackage

// File: cache/ahb_transfer_tracker.sv
module ahb_transfer_tracker (
    input  logic                    downstream_intf,
    input  logic                    arst_n,
    input  ahb_cache_pkg::ahb_req_t req,
    input  logic                    hready,
    output logic                    dvalid,
    output ahb_cache_pkg::addr_t    daddr
);

    logic rd_accept;

    // only active reads count, writes and BUSY look like idle
    always_comb begin
        rd_accept = 1'b0;
        case (req.htrans)
            ahb_cache_pkg::NONSEQ,
            ahb_cache_pkg::SEQ: begin
                rd_accept = !req.hwrite;
            end
            default: begin
                rd_accept = 1'b0;
            end
        endcase
    end

    // address phase moves to data phase on an hready edge
    always_ff @(posedge downstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            dvalid <= 1'b0;
        end else if (hready) begin
            dvalid <= rd_accept;
        end
    end

    // held while the data phase is stretched
    always_ff @(posedge downstream_intf) begin
        if (hready) begin
            daddr <= req.haddr;
        end
    end

endmodule

// File: cache/cache_tag_array.sv
module cache_tag_array #(
    parameter int CACHE_SIZE = 8192
) (
    input  logic                 downstream_intf,
    input  logic                 arst_n,
    input  ahb_cache_pkg::addr_t lookup_addr,
    output logic                 hit,
    output ahb_cache_pkg::data_t rd_word,
    input  logic                 fill_we,
    input  ahb_cache_pkg::addr_t fill_addr,
    input  ahb_cache_pkg::line_t fill_line
);

    localparam int LINE_BYTES = ahb_cache_pkg::LINE_WORDS * 4;
    localparam int OFS_W      = $clog2(LINE_BYTES);
    localparam int LINES      = CACHE_SIZE / LINE_BYTES;
    localparam int IDX_BITS   = $clog2(LINES);
    // a single-line cache still needs a one-bit index vector
    localparam int IDX_W      = (IDX_BITS > 0) ? IDX_BITS : 1;
    localparam int TAG_W      = 32 - OFS_W - IDX_BITS;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    ahb_cache_pkg::line_t line_q [LINES];
    tag_t                 tag_q  [LINES];
    logic [LINES-1:0]     valid_q;

    idx_t                    lk_idx;
    tag_t                    lk_tag;
    ahb_cache_pkg::word_sel_t lk_word;
    idx_t                    fl_idx;
    tag_t                    fl_tag;

    function automatic idx_t addr_idx(input ahb_cache_pkg::addr_t addr);
        if (IDX_BITS == 0) begin
            return '0;
        end
        return addr[OFS_W +: IDX_W];
    endfunction

    function automatic tag_t addr_tag(input ahb_cache_pkg::addr_t addr);
        return addr[31 -: TAG_W];
    endfunction

    // address split
    assign lk_idx  = addr_idx(lookup_addr);
    assign lk_tag  = addr_tag(lookup_addr);
    assign lk_word = lookup_addr[3:2];
    assign fl_idx  = addr_idx(fill_addr);
    assign fl_tag  = addr_tag(fill_addr);

    // combinational lookup
    assign hit     = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign rd_word = line_q[lk_idx][32*lk_word +: 32];

    always_ff @(posedge downstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (fill_we) begin
            valid_q[fl_idx] <= 1'b1;
        end
    end

    // whole line replaced in one edge
    always_ff @(posedge downstream_intf) begin
        if (fill_we) begin
            line_q[fl_idx] <= fill_line;
            tag_q[fl_idx]  <= fl_tag;
        end
    end

endmodule

// File: cache/line_fill_engine.sv
module line_fill_engine (
    input  logic                    downstream_intf,
    input  logic                    arst_n,
    input  logic                    up_dvalid,
    input  ahb_cache_pkg::addr_t    up_daddr,
    input  logic                    hit,
    input  logic                    mem_dvalid,
    input  ahb_cache_pkg::addr_t    mem_daddr,
    input  ahb_cache_pkg::ahb_rsp_t mem_rsp,
    output ahb_cache_pkg::ahb_req_t mem_req,
    output logic                    cpu_hready,
    output logic                    fill_we,
    output ahb_cache_pkg::addr_t    fill_addr,
    output ahb_cache_pkg::line_t    fill_line
);

    typedef enum logic [1:0] {
        idle,
        burst,
        drain,
        write
    } state_t;

    localparam ahb_cache_pkg::word_sel_t LAST_BEAT =
        ahb_cache_pkg::word_sel_t'(ahb_cache_pkg::LINE_WORDS - 1);

    state_t                    state;
    ahb_cache_pkg::htrans_t    mem_trans_q;
    ahb_cache_pkg::addr_t      mem_addr_q;
    ahb_cache_pkg::word_sel_t  iss_cnt;
    ahb_cache_pkg::word_sel_t  next_word;
    ahb_cache_pkg::line_t      line_buf;
    logic                      miss;
    logic                      beat_done;

    assign miss      = up_dvalid && !hit;
    assign beat_done = mem_dvalid && mem_rsp.hready;
    // WRAP4 stays inside the 16 byte line
    assign next_word = mem_addr_q[3:2] + 2'd1;

    always_ff @(posedge downstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            state       <= idle;
            mem_trans_q <= ahb_cache_pkg::IDLE;
            iss_cnt     <= '0;
        end else begin
            case (state)
                idle: begin
                    if (miss) begin
                        state       <= burst;
                        mem_trans_q <= ahb_cache_pkg::NONSEQ;
                        iss_cnt     <= '0;
                    end
                end
                burst: begin
                    if (mem_rsp.hready) begin
                        if (iss_cnt == LAST_BEAT) begin
                            mem_trans_q <= ahb_cache_pkg::IDLE;
                            state       <= drain;
                        end else begin
                            mem_trans_q <= ahb_cache_pkg::SEQ;
                            iss_cnt     <= iss_cnt + 2'd1;
                        end
                    end
                end
                drain: begin
                    // last data beat still in its data phase
                    if (beat_done) begin
                        state <= write;
                    end
                end
                write: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // critical word first, then wrap
    always_ff @(posedge downstream_intf) begin
        if (state == idle && miss) begin
            mem_addr_q <= {up_daddr[31:2], 2'b00};
        end else if (state == burst && mem_rsp.hready && iss_cnt != LAST_BEAT) begin
            mem_addr_q <= {mem_addr_q[31:4], next_word, 2'b00};
        end
    end

    // beats land by their own word select
    always_ff @(posedge downstream_intf) begin
        if (beat_done) begin
            line_buf[32*mem_daddr[3:2] +: 32] <= mem_rsp.hrdata;
        end
    end

    assign mem_req.haddr  = mem_addr_q;
    assign mem_req.htrans = mem_trans_q;
    assign mem_req.hwrite = 1'b0;
    assign mem_req.hburst = ahb_cache_pkg::HBURST_WRAP4;

    // low from the first data phase cycle of a miss until the refill hits
    assign cpu_hready = (state == idle) && !miss;

    assign fill_we   = (state == write);
    assign fill_addr = up_daddr;
    assign fill_line = line_buf;

endmodule

// File: design/ahb_cache_top.sv
module ahb_cache_top #(
    parameter int CACHE_SIZE = 8192
) (
    input  logic                  downstream_intf,
    input  logic                  arst_n,
    input  ahb_cache_pkg::ahb_req_t cpu_req,
    output ahb_cache_pkg::ahb_rsp_t cpu_rsp,
    output ahb_cache_pkg::ahb_req_t mem_req,
    input  ahb_cache_pkg::ahb_rsp_t mem_rsp
);

    logic                 up_dvalid;
    ahb_cache_pkg::addr_t up_daddr;
    logic                 mem_dvalid;
    ahb_cache_pkg::addr_t mem_daddr;
    logic                 hit;
    ahb_cache_pkg::data_t rd_word;
    logic                 cpu_hready;
    logic                 fill_we;
    ahb_cache_pkg::addr_t fill_addr;
    ahb_cache_pkg::line_t fill_line;

    // cpu side data phase
    ahb_transfer_tracker up_tracker (
        .downstream_intf (downstream_intf),
        .arst_n          (arst_n),
        .req             (cpu_req),
        .hready          (cpu_hready),
        .dvalid          (up_dvalid),
        .daddr           (up_daddr)
    );

    // memory side data phase, follows our own burst
    ahb_transfer_tracker mem_tracker (
        .downstream_intf (downstream_intf),
        .arst_n          (arst_n),
        .req             (mem_req),
        .hready          (mem_rsp.hready),
        .dvalid          (mem_dvalid),
        .daddr           (mem_daddr)
    );

    cache_tag_array #(
        .CACHE_SIZE (CACHE_SIZE)
    ) u_tag_array (
        .downstream_intf (downstream_intf),
        .arst_n          (arst_n),
        .lookup_addr     (up_daddr),
        .hit             (hit),
        .rd_word         (rd_word),
        .fill_we         (fill_we),
        .fill_addr       (fill_addr),
        .fill_line       (fill_line)
    );

    line_fill_engine u_fill_engine (
        .downstream_intf (downstream_intf),
        .arst_n          (arst_n),
        .up_dvalid       (up_dvalid),
        .up_daddr        (up_daddr),
        .hit             (hit),
        .mem_dvalid      (mem_dvalid),
        .mem_daddr       (mem_daddr),
        .mem_rsp         (mem_rsp),
        .mem_req         (mem_req),
        .cpu_hready      (cpu_hready),
        .fill_we         (fill_we),
        .fill_addr       (fill_addr),
        .fill_line       (fill_line)
    );

    assign cpu_rsp.hrdata = rd_word;
    assign cpu_rsp.hready = cpu_hready;

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic downstream_intf,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime HALF_PERIOD = 4ns;

    initial begin
        downstream_intf = 1'b0;
        forever #(HALF_PERIOD) downstream_intf = ~downstream_intf;
    end

    // held over the first four rising edges
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge downstream_intf);
        @(negedge downstream_intf);
        arst_n = 1'b1;
    end

endmodule

// File: tb/ahb_cache_chk.sv
module ahb_cache_chk (
    input logic                    downstream_intf,
    input logic                    arst_n,
    input ahb_cache_pkg::ahb_rsp_t cpu_rsp,
    input ahb_cache_pkg::ahb_req_t mem_req,
    input ahb_cache_pkg::ahb_rsp_t mem_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    // address phase frozen while the memory stretches a beat
    mem_req_held: assert property (@(posedge downstream_intf) disable iff (!arst_n)
        !mem_rsp.hready |=> $stable(mem_req))
        else $error("mem_req changed during a memory wait state");

    mem_burst_wrap4: assert property (@(posedge downstream_intf) disable iff (!arst_n)
        (mem_req.htrans != ahb_cache_pkg::IDLE) |-> (mem_req.hburst == ahb_cache_pkg::HBURST_WRAP4))
        else $error("memory transfer issued with a burst type other than WRAP4");

    mem_read_only: assert property (@(posedge downstream_intf) disable iff (!arst_n)
        !mem_req.hwrite)
        else $error("memory write issued by a read-only cache");

    cpu_ready_in_reset: assert property (@(posedge downstream_intf)
        !arst_n |-> cpu_rsp.hready)
        else $error("cpu hready low during reset");

endmodule

bind ahb_cache_top ahb_cache_chk u_chk (
    .downstream_intf (downstream_intf),
    .arst_n          (arst_n),
    .cpu_rsp         (cpu_rsp),
    .mem_req         (mem_req),
    .mem_rsp         (mem_rsp)
);

// File: tb/ahb_cache_tb.sv
module ahb_cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CACHE_SIZE  = 256;
    localparam int MODEL_LINES = CACHE_SIZE / 16;
    localparam int NUM_READS   = 2000;
    localparam int TIMEOUT     = 50;

    logic                    downstream_intf;
    logic                    arst_n;
    ahb_cache_pkg::ahb_req_t cpu_req;
    ahb_cache_pkg::ahb_rsp_t cpu_rsp;
    ahb_cache_pkg::ahb_req_t mem_req;
    ahb_cache_pkg::ahb_rsp_t mem_rsp;

    logic [31:0]          lfsr_state;
    ahb_cache_pkg::data_t mem_words [256];
    int                   model_tag [MODEL_LINES];
    logic                 model_valid [MODEL_LINES];
    ahb_cache_pkg::addr_t exp_beats [$];
    ahb_cache_pkg::addr_t recent_lines [$];
    ahb_cache_pkg::addr_t directed [5] = '{32'h000, 32'h004, 32'h100, 32'h008, 32'h00c};

    // memory slave state
    logic                 pend_valid;
    logic                 pend_first;
    ahb_cache_pkg::addr_t pend_addr;
    logic                 dp_active;
    ahb_cache_pkg::addr_t dp_addr;
    int                   waits_left;

    tb_clock_gen clock_gen (
        .downstream_intf (downstream_intf),
        .arst_n          (arst_n)
    );

    ahb_cache_top #(
        .CACHE_SIZE (CACHE_SIZE)
    ) UUT (
        .downstream_intf (downstream_intf),
        .arst_n          (arst_n),
        .cpu_req         (cpu_req),
        .cpu_rsp         (cpu_rsp),
        .mem_req         (mem_req),
        .mem_rsp         (mem_rsp)
    );

    // x^32 + x^22 + x^2 + x + 1, shifted right
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]};
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_bit()};
        end
        return val;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input ahb_cache_pkg::data_t got, input ahb_cache_pkg::data_t exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0d ns: %s got %08h expected %08h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_hit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0d ns: %s got %0b expected %0b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input ahb_cache_pkg::addr_t got, input ahb_cache_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0d ns: %s got %08h expected %08h",
                                     $time, what, got, exp));
        end
    endtask

    // called on every falling edge, sees what the last rising edge accepted
    task automatic serve_memory();
        ahb_cache_pkg::addr_t exp_addr;
        if (mem_rsp.hready) begin
            dp_active = pend_valid;
            if (pend_valid) begin
                if (exp_beats.size() == 0) begin
                    report_failure("unexpected downstream transfer on the memory bus");
                end
                check_hit(pend_first, exp_beats.size() == 4, "NONSEQ on the first beat only");
                exp_addr = exp_beats.pop_front();
                check_addr(pend_addr, exp_addr, "fill beat address");
                dp_addr = pend_addr;
                waits_left = rand_bits(2);
            end
        end
        if (dp_active && waits_left > 0) begin
            mem_rsp.hready = 1'b0;
            waits_left--;
        end else begin
            mem_rsp.hready = 1'b1;
            if (dp_active) begin
                mem_rsp.hrdata = mem_words[dp_addr[9:2]];
            end
        end
        pend_valid = (mem_req.htrans == ahb_cache_pkg::NONSEQ) ||
                     (mem_req.htrans == ahb_cache_pkg::SEQ);
        pend_first = (mem_req.htrans == ahb_cache_pkg::NONSEQ);
        pend_addr  = mem_req.haddr;
    endtask

    function automatic ahb_cache_pkg::addr_t pick_addr();
        ahb_cache_pkg::addr_t addr;
        // roughly 60 % go back to a recent line
        if (recent_lines.size() > 0 && rand_bits(7) < 77) begin
            addr = recent_lines[rand_bits(3) % recent_lines.size()] | (rand_bits(2) << 2);
        end else begin
            addr = rand_bits(8) << 2;
        end
        return addr;
    endfunction

    task automatic do_read(input ahb_cache_pkg::addr_t addr);
        int   wait_cnt;
        int   idx;
        int   tag;
        logic pred_hit;
        idx = (addr / 16) % MODEL_LINES;
        tag = addr / CACHE_SIZE;
        pred_hit = model_valid[idx] && (model_tag[idx] == tag);
        cpu_req.haddr  = addr;
        cpu_req.htrans = ahb_cache_pkg::NONSEQ;
        wait_cnt = 0;
        while (!cpu_rsp.hready) begin
            @(negedge downstream_intf);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                report_failure("timeout: the cache never accepted the read address");
            end
        end
        @(negedge downstream_intf);
        cpu_req.htrans = ahb_cache_pkg::IDLE;
        // first data phase cycle
        check_hit(cpu_rsp.hready, pred_hit, "hready in the first data phase cycle");
        if (!pred_hit) begin
            for (int b = 0; b < 4; b++) begin
                exp_beats.push_back((addr & 32'hffff_fff0) | ((addr + 4 * b) & 32'h0000_000c));
            end
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
        end
        wait_cnt = 0;
        while (!cpu_rsp.hready) begin
            @(negedge downstream_intf);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                report_failure("timeout: the read data phase never completed");
            end
        end
        check_word(cpu_rsp.hrdata, mem_words[addr[9:2]], "read data");
        check_hit(exp_beats.size() == 0, 1'b1, "all fill beats issued");
    endtask

    initial begin
        forever begin
            @(negedge downstream_intf);
            serve_memory();
        end
    end

    initial begin
        ahb_cache_pkg::addr_t addr;
        int                   wait_cnt;
        lfsr_state     = 32'd42;
        cpu_req.haddr  = '0;
        cpu_req.htrans = ahb_cache_pkg::IDLE;
        cpu_req.hwrite = 1'b0;
        cpu_req.hburst = ahb_cache_pkg::HBURST_SINGLE;
        mem_rsp.hready = 1'b1;
        mem_rsp.hrdata = '0;
        pend_valid = 1'b0;
        pend_first = 1'b0;
        pend_addr  = '0;
        dp_active  = 1'b0;
        dp_addr    = '0;
        waits_left = 0;
        for (int i = 0; i < MODEL_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = 0;
        end
        for (int i = 0; i < 256; i++) begin
            mem_words[i] = rand_bits(32);
        end
        wait_cnt = 0;
        while (arst_n !== 1'b1) begin
            @(negedge downstream_intf);
            wait_cnt++;
            if (wait_cnt > 20) begin
                report_failure("reset was never released");
            end
        end
        // line 0, a conflicting line 0x100, then back to line 0
        for (int i = 0; i < 5; i++) begin
            @(negedge downstream_intf);
            do_read(directed[i]);
        end
        for (int n = 5; n < NUM_READS; n++) begin
            addr = pick_addr();
            @(negedge downstream_intf);
            do_read(addr);
            recent_lines.push_back(addr & 32'hffff_fff0);
            if (recent_lines.size() > 8) begin
                void'(recent_lines.pop_front());
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: filelist.f
common/ahb_cache_pkg.sv
cache/ahb_transfer_tracker.sv
cache/cache_tag_array.sv
cache/line_fill_engine.sv
design/ahb_cache_top.sv
tb/tb_clock_gen.sv
tb/ahb_cache_chk.sv
tb/ahb_cache_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := ahb_cache_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "All tests passed!" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
